//--- verilog/core_pkg.sv
package core_pkg;

	// *******************************************************************
	// Widths with a meaning
	// *******************************************************************

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;

	// Major opcodes handled by the core
	localparam opcode_t OP_LUI = 7'b0110111;
	localparam opcode_t OP_IMM = 7'b0010011;
	localparam opcode_t OP_REG = 7'b0110011;

	// funct3 for the supported ALU functions
	localparam funct3_t F3_ADD = 3'b000;
	localparam funct3_t F3_XOR = 3'b100;
	localparam funct3_t F3_OR  = 3'b110;
	localparam funct3_t F3_AND = 3'b111;

	// funct7 for register-register forms
	localparam funct7_t F7_BASE = 7'b0000000;
	localparam funct7_t F7_SUB  = 7'b0100000;

	// *******************************************************************
	// Enums
	// *******************************************************************

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B,
		ALU_NONE
	} alu_op_t;

	// Fetch request FSM
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_REQ,
		FETCH_WAIT
	} fetch_state_t;

endpackage

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
	parameter int BUFFER_DEPTH = 4,
	parameter core_pkg::word_t RESET_PC = '0
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            credit_return,

	// Instruction memory port
	output logic            inst_start,
	input  logic            inst_ready,
	output core_pkg::word_t i_addr,
	input  core_pkg::word_t inst,
	input  logic            inst_valid,

	// Toward the instruction buffer
	output logic            push,
	output core_pkg::word_t push_inst,
	output core_pkg::word_t push_pc
);

	localparam int CREDIT_W = $clog2(BUFFER_DEPTH + 1);

	core_pkg::fetch_state_t state;
	core_pkg::fetch_state_t state_next;
	core_pkg::word_t        pc;
	logic [CREDIT_W-1:0]    credit_count;
	logic                   accept;
	logic                   credit_avail;

	// *******************************************************************
	// Memory handshake
	// *******************************************************************

	assign inst_start = (state == core_pkg::FETCH_REQ);
	assign accept     = inst_start && inst_ready;
	assign i_addr     = pc;

	// Word goes straight to the buffer in the valid cycle
	assign push      = (state == core_pkg::FETCH_WAIT) && inst_valid;
	assign push_inst = inst;
	assign push_pc   = pc;

	// A credit returned this cycle is usable by the next request
	assign credit_avail = (credit_count != '0) || credit_return;

	// *******************************************************************
	// Request FSM
	// *******************************************************************

	always_comb begin
		state_next = state;
		case (state)
			core_pkg::FETCH_IDLE: begin
				if (credit_avail)
					state_next = core_pkg::FETCH_REQ;
			end
			core_pkg::FETCH_REQ: begin
				if (inst_ready)
					state_next = core_pkg::FETCH_WAIT;
			end
			core_pkg::FETCH_WAIT: begin
				// Back-to-back request if a slot is still free
				if (inst_valid)
					state_next = credit_avail ? core_pkg::FETCH_REQ : core_pkg::FETCH_IDLE;
			end
			default: state_next = core_pkg::FETCH_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= core_pkg::FETCH_IDLE;
		else
			state <= state_next;
	end

	// Sequential fetch only
	always_ff @(posedge clk) begin
		if (reset)
			pc <= RESET_PC;
		else if (push)
			pc <= pc + 32'd4;
	end

	// *******************************************************************
	// Credit counter
	// *******************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			credit_count <= CREDIT_W'(BUFFER_DEPTH);
		end else begin
			case ({accept, credit_return})
				2'b10:   credit_count <= credit_count - CREDIT_W'(1);
				2'b01:   credit_count <= credit_count + CREDIT_W'(1);
				default: credit_count <= credit_count;
			endcase
		end
	end

endmodule

//--- verilog/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer #(
	parameter int BUFFER_DEPTH = 4
) (
	input  logic            clk,
	input  logic            reset,

	input  logic            push,
	input  core_pkg::word_t push_inst,
	input  core_pkg::word_t push_pc,

	input  logic            pop,
	output logic            head_valid,
	output core_pkg::word_t head_inst,
	output core_pkg::word_t head_pc,

	output logic            credit_return
);

	localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
	localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

	core_pkg::word_t  inst_mem [BUFFER_DEPTH];
	core_pkg::word_t  pc_mem   [BUFFER_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_pop;

	assign head_valid = (count != '0);
	assign head_inst  = inst_mem[rd_ptr];
	assign head_pc    = pc_mem[rd_ptr];

	// Ignore a pop on an empty queue
	assign do_pop = pop && head_valid;

	// Storage, no full check since credits bound the pushes
	always_ff @(posedge clk) begin
		if (push) begin
			inst_mem[wr_ptr] <= push_inst;
			pc_mem[wr_ptr]   <= push_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
			case ({push, do_pop})
				2'b10:   count <= count + CNT_W'(1);
				2'b01:   count <= count - CNT_W'(1);
				default: count <= count;
			endcase
		end
	end

	// One credit back per removed entry
	always_ff @(posedge clk) begin
		if (reset)
			credit_return <= 1'b0;
		else
			credit_return <= do_pop;
	end

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic                clk,
	input  logic                reset,
	input  logic                run,

	input  logic                head_valid,
	input  core_pkg::word_t     head_inst,
	input  core_pkg::word_t     head_pc,
	output logic                pop,

	output logic                retire_valid,
	output core_pkg::word_t     retire_pc,
	output core_pkg::word_t     retire_inst,
	output logic                retire_wen,
	output core_pkg::reg_addr_t retire_rd,
	output core_pkg::word_t     retire_value
);

	core_pkg::word_t     regs [32];

	core_pkg::opcode_t   opcode;
	core_pkg::funct3_t   funct3;
	core_pkg::funct7_t   funct7;
	core_pkg::reg_addr_t rd;
	core_pkg::reg_addr_t rs1;
	core_pkg::reg_addr_t rs2;
	core_pkg::word_t     imm_i;
	core_pkg::word_t     imm_u;
	core_pkg::word_t     op_a;
	core_pkg::word_t     op_b;
	core_pkg::alu_op_t   alu_op;
	core_pkg::word_t     result;
	logic                wen;

	// Consume the head whenever allowed to run
	assign pop = head_valid && run;

	// *******************************************************************
	// Decode
	// *******************************************************************

	assign opcode = head_inst[6:0];
	assign rd     = head_inst[11:7];
	assign funct3 = head_inst[14:12];
	assign rs1    = head_inst[19:15];
	assign rs2    = head_inst[24:20];
	assign funct7 = head_inst[31:25];

	assign imm_i = {{20{head_inst[31]}}, head_inst[31:20]};
	assign imm_u = {head_inst[31:12], 12'b0};

	// x0 is never written so it reads zero
	assign op_a = regs[rs1];

	always_comb begin
		alu_op = core_pkg::ALU_NONE;
		op_b   = regs[rs2];
		case (opcode)
			core_pkg::OP_LUI: begin
				alu_op = core_pkg::ALU_PASS_B;
				op_b   = imm_u;
			end
			core_pkg::OP_IMM: begin
				op_b = imm_i;
				case (funct3)
					core_pkg::F3_ADD: alu_op = core_pkg::ALU_ADD;
					core_pkg::F3_XOR: alu_op = core_pkg::ALU_XOR;
					core_pkg::F3_OR:  alu_op = core_pkg::ALU_OR;
					core_pkg::F3_AND: alu_op = core_pkg::ALU_AND;
					default:          alu_op = core_pkg::ALU_NONE;
				endcase
			end
			core_pkg::OP_REG: begin
				if (funct3 == core_pkg::F3_ADD && funct7 == core_pkg::F7_SUB)
					alu_op = core_pkg::ALU_SUB;
				else if (funct7 == core_pkg::F7_BASE) begin
					case (funct3)
						core_pkg::F3_ADD: alu_op = core_pkg::ALU_ADD;
						core_pkg::F3_XOR: alu_op = core_pkg::ALU_XOR;
						core_pkg::F3_OR:  alu_op = core_pkg::ALU_OR;
						core_pkg::F3_AND: alu_op = core_pkg::ALU_AND;
						default:          alu_op = core_pkg::ALU_NONE;
					endcase
				end
			end
			default: alu_op = core_pkg::ALU_NONE;
		endcase
	end

	// *******************************************************************
	// ALU and write-back
	// *******************************************************************

	always_comb begin
		case (alu_op)
			core_pkg::ALU_ADD:    result = op_a + op_b;
			core_pkg::ALU_SUB:    result = op_a - op_b;
			core_pkg::ALU_XOR:    result = op_a ^ op_b;
			core_pkg::ALU_OR:     result = op_a | op_b;
			core_pkg::ALU_AND:    result = op_a & op_b;
			core_pkg::ALU_PASS_B: result = op_b;
			default:              result = '0;
		endcase
	end

	assign wen = (alu_op != core_pkg::ALU_NONE) && (rd != '0);

	// Written on the pop edge, next pop sees it
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (pop && wen) begin
			regs[rd] <= result;
		end
	end

	// Retire report, one cycle after the pop
	always_ff @(posedge clk) begin
		if (reset) begin
			retire_valid <= 1'b0;
			retire_wen   <= 1'b0;
		end else begin
			retire_valid <= pop;
			if (pop)
				retire_wen <= wen;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			retire_pc    <= head_pc;
			retire_inst  <= head_inst;
			retire_rd    <= rd;
			retire_value <= wen ? result : '0;
		end
	end

endmodule

//--- verilog/core.sv
`timescale 1ns/1ps

module core #(
	parameter int BUFFER_DEPTH = 4,
	parameter core_pkg::word_t RESET_PC = '0
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                run,

	output logic                inst_start,
	input  logic                inst_ready,
	output core_pkg::word_t     i_addr,
	input  core_pkg::word_t     inst,
	input  logic                inst_valid,

	output logic                retire_valid,
	output core_pkg::word_t     retire_pc,
	output core_pkg::word_t     retire_inst,
	output logic                retire_wen,
	output core_pkg::reg_addr_t retire_rd,
	output core_pkg::word_t     retire_value
);

	// *******************************************************************
	// Fetch to buffer
	// *******************************************************************

	logic            push;
	core_pkg::word_t push_inst;
	core_pkg::word_t push_pc;
	logic            credit_return;

	fetch_stage #(
		.BUFFER_DEPTH(BUFFER_DEPTH),
		.RESET_PC    (RESET_PC)
	) u_fetch (
		.clk          (clk),
		.reset        (reset),
		.credit_return(credit_return),
		.inst_start   (inst_start),
		.inst_ready   (inst_ready),
		.i_addr       (i_addr),
		.inst         (inst),
		.inst_valid   (inst_valid),
		.push         (push),
		.push_inst    (push_inst),
		.push_pc      (push_pc)
	);

	// *******************************************************************
	// Buffer to execute
	// *******************************************************************

	logic            pop;
	logic            head_valid;
	core_pkg::word_t head_inst;
	core_pkg::word_t head_pc;

	inst_buffer #(
		.BUFFER_DEPTH(BUFFER_DEPTH)
	) u_buffer (
		.clk          (clk),
		.reset        (reset),
		.push         (push),
		.push_inst    (push_inst),
		.push_pc      (push_pc),
		.pop          (pop),
		.head_valid   (head_valid),
		.head_inst    (head_inst),
		.head_pc      (head_pc),
		.credit_return(credit_return)
	);

	execute_stage u_execute (
		.clk         (clk),
		.reset       (reset),
		.run         (run),
		.head_valid  (head_valid),
		.head_inst   (head_inst),
		.head_pc     (head_pc),
		.pop         (pop),
		.retire_valid(retire_valid),
		.retire_pc   (retire_pc),
		.retire_inst (retire_inst),
		.retire_wen  (retire_wen),
		.retire_rd   (retire_rd),
		.retire_value(retire_value)
	);

endmodule

//--- dv/core_assertions.sv
`timescale 1ns/1ps

module core_assertions #(
	parameter int BUFFER_DEPTH = 4
) (
	input logic                                  clk,
	input logic                                  reset,
	input logic                                  inst_start,
	input logic                                  inst_ready,
	input core_pkg::word_t                       i_addr,
	input logic [$clog2(BUFFER_DEPTH + 1)-1:0]   credit_count
);

	localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

	// Request held until accepted, address frozen meanwhile
	a_addr_stable: assert property (@(posedge clk) disable iff (reset)
		(inst_start && !inst_ready) |=> (inst_start && $stable(i_addr)))
		else $error("i_addr or inst_start changed before acceptance");

	a_credit_held: assert property (@(posedge clk) disable iff (reset)
		inst_start |-> (credit_count != '0))
		else $error("inst_start raised with no credit left");

	a_credit_max: assert property (@(posedge clk) disable iff (reset)
		credit_count <= CNT_W'(BUFFER_DEPTH))
		else $error("credit count above buffer depth");

endmodule

bind fetch_stage core_assertions #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_assertions (
	.clk         (clk),
	.reset       (reset),
	.inst_start  (inst_start),
	.inst_ready  (inst_ready),
	.i_addr      (i_addr),
	.credit_count(credit_count)
);

//--- dv/tb_core.sv
`timescale 1ns/1ps

module tb_core;

	localparam int              BUFFER_DEPTH   = 4;
	localparam core_pkg::word_t RESET_PC       = 32'h0;
	localparam int              TIMEOUT_CYCLES = 2000;

	logic                clk;
	logic                reset = 1'b1;
	logic                run = 1'b0;
	logic                inst_ready = 1'b0;
	core_pkg::word_t     inst = '0;
	logic                inst_valid = 1'b0;
	logic                inst_start;
	core_pkg::word_t     i_addr;
	logic                retire_valid;
	core_pkg::word_t     retire_pc;
	core_pkg::word_t     retire_inst;
	logic                retire_wen;
	core_pkg::reg_addr_t retire_rd;
	core_pkg::word_t     retire_value;

	core_pkg::word_t mem [0:255];
	core_pkg::word_t model_regs [32];
	core_pkg::word_t model_pc;
	core_pkg::word_t req_addr;
	core_pkg::word_t first_addr;
	logic [31:0]     lfsr = 32'd82983;
	logic [7:0]      lat_cnt;
	logic [7:0]      gap_cnt;
	logic            busy;
	logic            first_seen;
	logic            random_mode = 1'b0;
	int              prog_len;
	int              accept_cnt;
	int              retire_cnt;
	int              mon_errs = 0;
	int              test_errs = 0;
	int              timeouts = 0;

	core #(
		.BUFFER_DEPTH(BUFFER_DEPTH),
		.RESET_PC    (RESET_PC)
	) DUT (
		.clk(clk), .reset(reset), .run(run),
		.inst_start(inst_start), .inst_ready(inst_ready), .i_addr(i_addr),
		.inst(inst), .inst_valid(inst_valid),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_inst(retire_inst),
		.retire_wen(retire_wen), .retire_rd(retire_rd), .retire_value(retire_value)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		logic       fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[6:0], fb};
		end
		return v;
	endfunction

	function automatic core_pkg::word_t itype(input logic [2:0] f3, input int rd, input int rs1,
		input int imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
	endfunction

	function automatic core_pkg::word_t rtype(input logic [6:0] f7, input logic [2:0] f3,
		input int rd, input int rs1, input int rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
	endfunction

	function automatic core_pkg::word_t lui_word(input int rd, input int imm20);
		return {imm20[19:0], rd[4:0], 7'b0110111};
	endfunction

	// Reference model of the ten instructions
	function automatic void predict(input core_pkg::word_t w, output logic wen,
		output core_pkg::word_t value);
		core_pkg::word_t a;
		core_pkg::word_t b;
		core_pkg::word_t imm;
		logic            ok;
		a = model_regs[w[19:15]];
		b = model_regs[w[24:20]];
		imm = {{20{w[31]}}, w[31:20]};
		ok = 1'b1;
		value = '0;
		if (w[6:0] == 7'b0110111)
			value = {w[31:12], 12'h000};
		else if (w[6:0] == 7'b0010011) begin
			case (w[14:12])
				3'd0: value = a + imm;
				3'd4: value = a ^ imm;
				3'd6: value = a | imm;
				3'd7: value = a & imm;
				default: ok = 1'b0;
			endcase
		end else if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0100000 && w[14:12] == 3'd0)
			value = a - b;
		else if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0000000) begin
			case (w[14:12])
				3'd0: value = a + b;
				3'd4: value = a ^ b;
				3'd6: value = a | b;
				3'd7: value = a & b;
				default: ok = 1'b0;
			endcase
		end else
			ok = 1'b0;
		wen = ok && (w[11:7] != 5'd0);
		if (!wen)
			value = '0;
	endfunction

	// ******************************************************************
	// Instruction memory model
	// ******************************************************************

	always @(posedge clk) begin
		if (reset) begin
			inst_ready <= 1'b0;
			inst_valid <= 1'b0;
			busy       <= 1'b0;
			lat_cnt    <= 8'd0;
			gap_cnt    <= 8'd0;
			accept_cnt <= 0;
			first_seen <= 1'b0;
		end else begin
			inst_valid <= 1'b0;
			if (busy) begin
				if (lat_cnt == 8'd0) begin
					inst_valid <= 1'b1;
					inst       <= mem[req_addr[9:2]];
					busy       <= 1'b0;
					gap_cnt    <= random_mode ? rand_bits(2) : 8'd0;
				end else
					lat_cnt <= lat_cnt - 8'd1;
			end else if (inst_start && inst_ready) begin
				busy       <= 1'b1;
				req_addr   <= i_addr;
				inst_ready <= 1'b0;
				lat_cnt    <= random_mode ? rand_bits(3) : 8'd0;
				accept_cnt <= accept_cnt + 1;
				if (!first_seen) begin
					first_seen <= 1'b1;
					first_addr <= i_addr;
				end
			end else if (gap_cnt != 8'd0)
				gap_cnt <= gap_cnt - 8'd1;
			else
				inst_ready <= 1'b1;
		end
	end

	// Retire monitor, in order against the model
	always @(posedge clk) begin
		core_pkg::word_t exp_inst;
		core_pkg::word_t exp_value;
		logic            exp_wen;
		if (reset) begin
			model_pc   <= RESET_PC;
			retire_cnt <= 0;
			for (int i = 0; i < 32; i++)
				model_regs[i] = '0;
		end else if (retire_valid) begin
			exp_inst = mem[model_pc[9:2]];
			predict(exp_inst, exp_wen, exp_value);
			if (retire_pc !== model_pc || retire_inst !== exp_inst || retire_wen !== exp_wen
				|| retire_rd !== exp_inst[11:7] || retire_value !== exp_value) begin
				$display("ERR %0t: got pc %h inst %h wen %b rd %0d val %h, exp %h %h %b %0d %h",
					$time, retire_pc, retire_inst, retire_wen, retire_rd, retire_value,
					model_pc, exp_inst, exp_wen, exp_inst[11:7], exp_value);
				mon_errs = mon_errs + 1;
			end
			if (exp_wen)
				model_regs[exp_inst[11:7]] = exp_value;
			model_pc   <= model_pc + 32'd4;
			retire_cnt <= retire_cnt + 1;
		end
	end

	// ******************************************************************
	// Test helpers
	// ******************************************************************

	// Reset for 4 cycles, memory refilled with unsupported words
	task automatic hold_reset(input logic rmode);
		@(posedge clk);
		reset       <= 1'b1;
		run         <= 1'b0;
		random_mode <= rmode;
		// First edge that samples reset high
		@(posedge clk);
		repeat (3) begin
			@(negedge clk);
			if (inst_start !== 1'b0 || retire_valid !== 1'b0) begin
				$display("ERR %0t: inst_start or retire_valid high in reset", $time);
				test_errs++;
			end
		end
		for (int i = 0; i < 256; i++)
			mem[i] = {i[24:0], 7'h7F};
		prog_len = 0;
	endtask

	task automatic emit(input core_pkg::word_t w);
		mem[prog_len] = w;
		prog_len++;
	endtask

	task automatic release_core(input logic run_now);
		@(posedge clk);
		reset <= 1'b0;
		run   <= run_now;
	endtask

	task automatic wait_retired(input string name);
		int cycles;
		cycles = 0;
		while (retire_cnt < prog_len && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (retire_cnt < prog_len) begin
			$display("Timeout in %s: only %0d of %0d instructions retired", name, retire_cnt,
				prog_len);
			timeouts++;
		end
	endtask

	// ******************************************************************
	// Directed tests
	// ******************************************************************

	task automatic reset_and_first_fetch();
		int cycles;
		hold_reset(1'b0);
		emit(itype(3'd0, 1, 0, 9));
		emit(itype(3'd0, 2, 1, 1));
		release_core(1'b1);
		cycles = 0;
		while (!first_seen && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (!first_seen) begin
			$display("Timeout: no fetch request was accepted after reset");
			timeouts++;
		end else if (first_addr != RESET_PC) begin
			$display("ERR %0t: first i_addr %h, expected %h", $time, first_addr, RESET_PC);
			test_errs++;
		end
		wait_retired("reset_and_first_fetch");
	endtask

	task automatic imm_program();
		hold_reset(1'b0);
		emit(lui_word(1, 32'h12345));
		emit(itype(3'd0, 2, 1, 32'h678));
		emit(itype(3'd4, 3, 2, -1));
		emit(itype(3'd6, 4, 3, 32'h0F0));
		emit(itype(3'd7, 5, 4, 32'h7FF));
		emit(itype(3'd0, 6, 5, -2048));
		release_core(1'b1);
		wait_retired("imm_program");
	endtask

	// Each result feeds the next instruction
	task automatic reg_dependencies();
		hold_reset(1'b0);
		emit(itype(3'd0, 1, 0, 5));
		emit(itype(3'd0, 2, 0, -3));
		emit(rtype(7'h00, 3'd0, 3, 1, 2));
		emit(rtype(7'h20, 3'd0, 4, 3, 1));
		emit(rtype(7'h00, 3'd4, 5, 4, 3));
		emit(rtype(7'h00, 3'd6, 6, 5, 4));
		emit(rtype(7'h00, 3'd7, 7, 6, 5));
		emit(rtype(7'h00, 3'd0, 7, 7, 7));
		emit(rtype(7'h20, 3'd0, 1, 7, 1));
		release_core(1'b1);
		wait_retired("reg_dependencies");
	endtask

	task automatic back_pressure();
		hold_reset(1'b0);
		for (int k = 0; k < 10; k++)
			emit(itype(3'd0, 1 + k % 5, k % 5, k * 3));
		release_core(1'b0);
		repeat (40) begin
			@(negedge clk);
			if (accept_cnt > BUFFER_DEPTH || retire_valid !== 1'b0) begin
				$display("ERR %0t: %0d requests accepted with run low", $time, accept_cnt);
				test_errs++;
			end
		end
		if (accept_cnt != BUFFER_DEPTH) begin
			$display("ERR %0t: %0d requests accepted, expected %0d", $time, accept_cnt,
				BUFFER_DEPTH);
			test_errs++;
		end
		@(posedge clk);
		run <= 1'b1;
		wait_retired("back_pressure");
	endtask

	task automatic random_latency();
		hold_reset(1'b1);
		for (int k = 0; k < 24; k++) begin
			if (k % 3 == 0)
				emit(itype(3'd0, 1 + k % 7, k % 6, 100 - k * 9));
			else if (k % 3 == 1)
				emit(rtype(k % 2 == 0 ? 7'h20 : 7'h00, 3'd0, 1 + k % 7, 1 + k % 5, 2 + k % 4));
			else
				emit(itype(3'd4, 1 + k % 7, 1 + k % 6, k * 37));
		end
		release_core(1'b1);
		wait_retired("random_latency");
	endtask

	task automatic x0_and_unsupported();
		hold_reset(1'b0);
		emit(itype(3'd0, 3, 0, 32'h55));
		emit(itype(3'd0, 0, 3, 7));
		emit(rtype(7'h00, 3'd0, 4, 0, 0));
		emit(32'h0000_0183);
		emit(rtype(7'h00, 3'd2, 3, 3, 3));
		emit(itype(3'd0, 5, 3, 0));
		emit(rtype(7'h00, 3'd6, 6, 0, 3));
		release_core(1'b1);
		wait_retired("x0_and_unsupported");
	endtask

	initial begin
		reset_and_first_fetch();
		imm_program();
		reg_dependencies();
		back_pressure();
		random_latency();
		x0_and_unsupported();
		@(posedge clk);
		@(negedge clk);
		$display("Value errors: %0d, timeouts: %0d", mon_errs + test_errs, timeouts);
		if (mon_errs + test_errs + timeouts == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- tb.f
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/inst_buffer.sv
verilog/execute_stage.sv
verilog/core.sv
dv/core_assertions.sv
dv/tb_core.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_core -Mdir obj_dir \
	&& ./obj_dir/Vtb_core > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation stopped with an error"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log \
	&& { echo "Result: FAIL"; exit 1; } \
	|| { echo "Result: PASS"; exit 0; }
